// ==== sources.f ====
+incdir+.
jtag_pkg.sv
jtag_driver.sv
jtag_tap_fsm.sv
jtag_target_regs.sv
jtag_sim_top.sv
tb_jtag_top.sv

// ==== Makefile ====
# Verilator flow for the JTAG subsystem

VERILATOR  ?= verilator
TOP        ?= tb_jtag_top
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
PASS_TEXT  ?= === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_TEXT)'

clean:
	rm -rf $(OBJ_DIR)

// ==== tb_jtag_top.sv ====
// testbench for the JTAG simulation top
// drives handshaked scan commands and checks responses with concurrent assertions
`timescale 1ns/1ps
`include "jtag_macros.svh"

module tb_jtag_top;

  localparam int clk_period = 100;
  localparam int reset_cycles = 10;
  localparam int hold_cycles = 40;
  localparam int num_cmds = 19;
  // a full DR scan is the longest command, plus handshake and back-pressure slack
  localparam int step_clocks = `JTAG_TICK_DELAY + 1;
  localparam int max_cmd_clocks = (3 + `JTAG_DR_WIDTH + 2) * 2 * step_clocks + 16;
  localparam longint watchdog_ns =
    2 * longint'(num_cmds * max_cmd_clocks + hold_cycles + reset_cycles) * clk_period;

  logic                      clock;
  logic                      reset;
  logic                      enable;
  logic                      init_done;
  logic                      req;
  jtag_pkg::cmd_word_u       cmd;
  logic                      ack;
  logic [`JTAG_DR_WIDTH-1:0] rsp_data;
  logic                      rsp_fault;

  logic                      pin_tck;
  logic                      pin_tms;
  logic                      pin_tdi;
  logic [15:0]               lfsr_state;
  logic                      init_seen;
  logic                      hold;
  logic                      check_data;
  logic [`JTAG_DR_WIDTH-1:0] exp_data;
  int                        value_errors;
  int                        protocol_errors;
  int                        responses;

  jtag_sim_top dut_i (
    .clock     (clock),
    .reset     (reset),
    .enable    (enable),
    .init_done (init_done),
    .req       (req),
    .cmd       (cmd),
    .ack       (ack),
    .rsp_data  (rsp_data),
    .rsp_fault (rsp_fault)
  );

  assign pin_tck = dut_i.tck;
  assign pin_tms = dut_i.tms;
  assign pin_tdi = dut_i.tdi;

  initial begin
    clock = 1'b0;
    forever #(clk_period / 2) clock = ~clock;
  end

  // init_done is sticky, so the driver is held until it has been seen once
  always @(posedge clock) begin
    if (reset) begin
      init_seen <= 1'b0;
    end else if (init_done) begin
      init_seen <= 1'b1;
    end
  end

  assign hold = !enable || !init_seen;

  // 16-bit Fibonacci LFSR, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic random_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] low_mask(input int n);
    return (n >= 32) ? 32'hFFFF_FFFF : ((32'd1 << n) - 32'd1);
  endfunction

  // bypass puts a 0 in front of the shifted data
  function automatic logic [31:0] bypass_expect(input int n, input logic [31:0] d);
    return {d[30:0], 1'b0} & low_mask(n);
  endfunction

  function automatic jtag_pkg::cmd_word_u ir_cmd(input logic [3:0] instr);
    jtag_pkg::cmd_word_u w;
    w = '0;
    w.ir_view.op = jtag_pkg::op_ir_scan;
    w.ir_view.instr = instr;
    return w;
  endfunction

  function automatic jtag_pkg::cmd_word_u dr_cmd(input int len, input logic [31:0] data);
    jtag_pkg::cmd_word_u w;
    w = '0;
    w.dr_view.op = jtag_pkg::op_dr_scan;
    w.dr_view.len_m1 = 6'(len - 1);
    w.dr_view.data = data;
    return w;
  endfunction

  function automatic jtag_pkg::cmd_word_u op_cmd(input jtag_pkg::scan_op_e op);
    jtag_pkg::cmd_word_u w;
    w = '0;
    w.dr_view.op = op;
    return w;
  endfunction

  task automatic raise_req(input jtag_pkg::cmd_word_u word, input logic check,
                           input logic [31:0] expected);
    @(posedge clock);
    cmd        <= word;
    req        <= 1'b1;
    check_data <= check;
    exp_data   <= expected;
  endtask

  // wait for ack, hold req a few random cycles, then close the handshake
  task automatic complete_req();
    logic [31:0] delay;
    do @(posedge clock); while (!ack);
    random_bits(3, delay);
    repeat (delay) @(posedge clock);
    req <= 1'b0;
    do @(posedge clock); while (ack);
    responses++;
  endtask

  task automatic run_cmd(input jtag_pkg::cmd_word_u word, input logic check,
                         input logic [31:0] expected);
    raise_req(word, check, expected);
    complete_req();
  endtask

  pins_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> {ack, rsp_fault, pin_tck, pin_tms, pin_tdi} == 5'b0)
  else begin
    protocol_errors++;
    $display("error at %0t: {ack,rsp_fault,tck,tms,tdi} = %b, expected 00000", $time,
             $sampled({ack, rsp_fault, pin_tck, pin_tms, pin_tdi}));
  end

  held_driver_still: assert property (@(posedge clock) disable iff (reset)
    hold |=> $stable(pin_tck) && $stable(ack))
  else begin
    protocol_errors++;
    $display("tck or ack moved at %0t while the driver was held", $time);
  end

  ack_rise_with_req: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> req)
  else begin
    protocol_errors++;
    $display("ack rose at %0t while req was low", $time);
  end

  ack_fall_after_req: assert property (@(posedge clock) disable iff (reset)
    $fell(ack) |-> !$past(req))
  else begin
    protocol_errors++;
    $display("ack fell at %0t before req was dropped", $time);
  end

  pins_idle_on_ack: assert property (@(posedge clock) disable iff (reset)
    ack |-> {pin_tck, pin_tms, pin_tdi} == 3'b0)
  else begin
    protocol_errors++;
    $display("error at %0t: {tck,tms,tdi} = %b, expected 000", $time,
             $sampled({pin_tck, pin_tms, pin_tdi}));
  end

  response_held: assert property (@(posedge clock) disable iff (reset)
    ack && $past(ack) |-> $stable(rsp_data) && $stable(rsp_fault))
  else begin
    protocol_errors++;
    $display("response changed at %0t while ack was high", $time);
  end

  data_matches: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) && check_data |-> rsp_data == exp_data)
  else begin
    value_errors++;
    $display("error at %0t: rsp_data = %h, expected %h", $time, $sampled(rsp_data),
             $sampled(exp_data));
  end

  fault_clear: assert property (@(posedge clock) disable iff (reset)
    $rose(ack) |-> !rsp_fault)
  else begin
    value_errors++;
    $display("error at %0t: rsp_fault = %b, expected 0", $time, $sampled(rsp_fault));
  end

  initial begin : watchdog
    #(watchdog_ns);
    $display("timeout after %0d ns, the driver never finished a command", watchdog_ns);
    $display("responses %0d, value errors %0d, protocol errors %0d", responses,
             value_errors, protocol_errors);
    $display("=== FAIL ===");
    $finish;
  end

  initial begin : main
    logic [31:0] data_a;
    logic [31:0] data_b;
    logic [31:0] rnd;
    int          len;
    reset           = 1'b1;
    enable          = 1'b0;
    init_done       = 1'b0;
    req             = 1'b0;
    cmd             = '0;
    check_data      = 1'b0;
    exp_data        = '0;
    lfsr_state      = 16'd75;
    value_errors    = 0;
    protocol_errors = 0;
    responses       = 0;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;

    // req waits first for init_done, then for enable
    @(posedge clock);
    enable <= 1'b1;
    raise_req(op_cmd(jtag_pkg::op_idle), 1'b0, '0);
    repeat (hold_cycles / 2) @(posedge clock);
    init_done <= 1'b1;
    enable    <= 1'b0;
    @(posedge clock);
    init_done <= 1'b0;
    repeat (hold_cycles / 2) @(posedge clock);
    enable <= 1'b1;
    complete_req();

    random_bits(32, rnd);
    run_cmd(dr_cmd(32, rnd), 1'b1, `JTAG_IDCODE_VALUE);

    // USER returns what the previous scan left in it
    random_bits(32, data_a);
    random_bits(32, data_b);
    run_cmd(ir_cmd(`JTAG_INSTR_USER), 1'b0, '0);
    run_cmd(dr_cmd(32, data_a), 1'b1, 32'h0);
    run_cmd(dr_cmd(32, data_b), 1'b1, data_a);

    run_cmd(op_cmd(jtag_pkg::op_tap_reset), 1'b0, '0);
    random_bits(32, rnd);
    run_cmd(dr_cmd(32, rnd), 1'b1, `JTAG_IDCODE_VALUE);

    run_cmd(ir_cmd(`JTAG_INSTR_BYPASS), 1'b0, '0);
    for (int i = 0; i < 8; i++) begin
      random_bits(5, rnd);
      len = int'(rnd) + 1;
      if (i == 0) begin
        len = 1;
      end else if (i == 1) begin
        len = 32;
      end
      random_bits(32, rnd);
      run_cmd(dr_cmd(len, rnd), 1'b1, bypass_expect(len, rnd));
    end

    run_cmd(op_cmd(jtag_pkg::op_idle), 1'b0, '0);
    // short scan of IDCODE returns its low bits
    run_cmd(ir_cmd(`JTAG_INSTR_IDCODE), 1'b0, '0);
    random_bits(16, rnd);
    run_cmd(dr_cmd(16, rnd), 1'b1, `JTAG_IDCODE_VALUE & low_mask(16));

    repeat (4) @(posedge clock);
    $display("responses %0d, value errors %0d, protocol errors %0d", responses,
             value_errors, protocol_errors);
    if (value_errors == 0 && protocol_errors == 0 && responses == num_cmds) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== jtag_sim_top.sv ====
// JTAG simulation top
// host driver wired to one TAP target over the JTAG pins
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_sim_top (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      enable,
  input  logic                      init_done,
  input  logic                      req,
  input  jtag_pkg::cmd_word_u       cmd,
  output logic                      ack,
  output logic [`JTAG_DR_WIDTH-1:0] rsp_data,
  output logic                      rsp_fault
);

  // JTAG pins
  logic                 tck;
  logic                 tms;
  logic                 tdi;
  logic                 tdo_data;
  logic                 tdo_driven;

  // target internals
  jtag_pkg::tap_state_e state;
  logic                 tck_rise;
  logic                 tck_fall;

  jtag_driver driver_i (
    .clock      (clock),
    .reset      (reset),
    .enable     (enable),
    .init_done  (init_done),
    .req        (req),
    .cmd        (cmd),
    .tdo_data   (tdo_data),
    .tdo_driven (tdo_driven),
    .ack        (ack),
    .rsp_data   (rsp_data),
    .rsp_fault  (rsp_fault),
    .tck        (tck),
    .tms        (tms),
    .tdi        (tdi)
  );

  jtag_tap_fsm tap_fsm_i (
    .clock    (clock),
    .reset    (reset),
    .tck      (tck),
    .tms      (tms),
    .state    (state),
    .tck_rise (tck_rise),
    .tck_fall (tck_fall)
  );

  jtag_target_regs target_regs_i (
    .clock      (clock),
    .reset      (reset),
    .state      (state),
    .tck_rise   (tck_rise),
    .tck_fall   (tck_fall),
    .tdi        (tdi),
    .tdo_data   (tdo_data),
    .tdo_driven (tdo_driven)
  );

endmodule

// ==== jtag_target_regs.sv ====
// JTAG target registers
// IR plus IDCODE, BYPASS and USER data registers with retimed TDO
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_target_regs (
  input  logic                 clock,
  input  logic                 reset,
  input  jtag_pkg::tap_state_e state,
  input  logic                 tck_rise,
  input  logic                 tck_fall,
  input  logic                 tdi,
  output logic                 tdo_data,
  output logic                 tdo_driven
);

  localparam int ir_w = `JTAG_IR_WIDTH;
  localparam int dr_w = `JTAG_DR_WIDTH;

  logic [ir_w-1:0] ir_shift;
  logic [ir_w-1:0] ir;
  logic [dr_w-1:0] dr_shift;
  logic [dr_w-1:0] dr_capture;
  logic [dr_w-1:0] user_reg;
  logic            sel_idcode;
  logic            sel_user;
  logic            sel_bypass;

  // instruction decode, unknown codes fall back to bypass
  assign sel_idcode = (ir == `JTAG_INSTR_IDCODE);
  assign sel_user = (ir == `JTAG_INSTR_USER);
  assign sel_bypass = !(sel_idcode || sel_user);

  always_comb begin
    if (sel_idcode) begin
      dr_capture = `JTAG_IDCODE_VALUE;
    end else if (sel_user) begin
      dr_capture = user_reg;
    end else begin
      dr_capture = '0;
    end
  end

  // capture and shift act on the rising edge in the current state
  always_ff @(posedge clock) begin
    if (tck_rise) begin
      case (state)
        jtag_pkg::tap_capture_ir: ir_shift <= ir_w'(1);
        jtag_pkg::tap_shift_ir: ir_shift <= {tdi, ir_shift[ir_w-1:1]};
        jtag_pkg::tap_capture_dr: dr_shift <= dr_capture;
        jtag_pkg::tap_shift_dr: begin
          // bypass is a single stage at bit 0
          if (sel_bypass) begin
            dr_shift[0] <= tdi;
          end else begin
            dr_shift <= {tdi, dr_shift[dr_w-1:1]};
          end
        end
        default: ;
      endcase
    end
  end

  // instruction register, forced to IDCODE in test-logic-reset
  always_ff @(posedge clock) begin
    if (reset) begin
      ir <= `JTAG_INSTR_IDCODE;
    end else if (state == jtag_pkg::tap_test_logic_reset) begin
      ir <= `JTAG_INSTR_IDCODE;
    end else if (tck_fall && (state == jtag_pkg::tap_update_ir)) begin
      ir <= ir_shift;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      user_reg <= '0;
    end else if (tck_fall && (state == jtag_pkg::tap_update_dr) && sel_user) begin
      user_reg <= dr_shift;
    end
  end

  // TDO changes only on falling edges
  always_ff @(posedge clock) begin
    if (reset) begin
      tdo_data <= 1'b0;
    end else if (tck_fall) begin
      tdo_data <= (state == jtag_pkg::tap_shift_ir) ? ir_shift[0] : dr_shift[0];
    end
  end

  assign tdo_driven = (state == jtag_pkg::tap_shift_ir) || (state == jtag_pkg::tap_shift_dr);

endmodule

// ==== jtag_tap_fsm.sv ====
// TAP controller for the JTAG target
// steps the 16-state machine on sampled TCK rising edges
`timescale 1ns/1ps

module jtag_tap_fsm (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 tck,
  input  logic                 tms,
  output jtag_pkg::tap_state_e state,
  output logic                 tck_rise,
  output logic                 tck_fall
);

  logic                 tck_prev;
  jtag_pkg::tap_state_e state_next;

  // tck is only a sampled pin here
  // edges come from comparing against the last sample
  assign tck_rise = tck && !tck_prev;
  assign tck_fall = !tck && tck_prev;

  always_comb begin
    case (state)
      jtag_pkg::tap_test_logic_reset: begin
        state_next = tms ? jtag_pkg::tap_test_logic_reset : jtag_pkg::tap_run_test_idle;
      end
      jtag_pkg::tap_run_test_idle: begin
        state_next = tms ? jtag_pkg::tap_select_dr : jtag_pkg::tap_run_test_idle;
      end
      // data register column
      jtag_pkg::tap_select_dr: begin
        state_next = tms ? jtag_pkg::tap_select_ir : jtag_pkg::tap_capture_dr;
      end
      jtag_pkg::tap_capture_dr: begin
        state_next = tms ? jtag_pkg::tap_exit1_dr : jtag_pkg::tap_shift_dr;
      end
      jtag_pkg::tap_shift_dr: begin
        state_next = tms ? jtag_pkg::tap_exit1_dr : jtag_pkg::tap_shift_dr;
      end
      jtag_pkg::tap_exit1_dr: begin
        state_next = tms ? jtag_pkg::tap_update_dr : jtag_pkg::tap_pause_dr;
      end
      jtag_pkg::tap_pause_dr: begin
        state_next = tms ? jtag_pkg::tap_exit2_dr : jtag_pkg::tap_pause_dr;
      end
      jtag_pkg::tap_exit2_dr: begin
        state_next = tms ? jtag_pkg::tap_update_dr : jtag_pkg::tap_shift_dr;
      end
      jtag_pkg::tap_update_dr: begin
        state_next = tms ? jtag_pkg::tap_select_dr : jtag_pkg::tap_run_test_idle;
      end
      // instruction register column
      jtag_pkg::tap_select_ir: begin
        state_next = tms ? jtag_pkg::tap_test_logic_reset : jtag_pkg::tap_capture_ir;
      end
      jtag_pkg::tap_capture_ir: begin
        state_next = tms ? jtag_pkg::tap_exit1_ir : jtag_pkg::tap_shift_ir;
      end
      jtag_pkg::tap_shift_ir: begin
        state_next = tms ? jtag_pkg::tap_exit1_ir : jtag_pkg::tap_shift_ir;
      end
      jtag_pkg::tap_exit1_ir: begin
        state_next = tms ? jtag_pkg::tap_update_ir : jtag_pkg::tap_pause_ir;
      end
      jtag_pkg::tap_pause_ir: begin
        state_next = tms ? jtag_pkg::tap_exit2_ir : jtag_pkg::tap_pause_ir;
      end
      jtag_pkg::tap_exit2_ir: begin
        state_next = tms ? jtag_pkg::tap_update_ir : jtag_pkg::tap_shift_ir;
      end
      jtag_pkg::tap_update_ir: begin
        state_next = tms ? jtag_pkg::tap_select_dr : jtag_pkg::tap_run_test_idle;
      end
      default: state_next = jtag_pkg::tap_test_logic_reset;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tck_prev <= 1'b0;
      state    <= jtag_pkg::tap_test_logic_reset;
    end else begin
      tck_prev <= tck;
      // tms is still the value the host set up before the rise
      if (tck_rise) begin
        state <= state_next;
      end
    end
  end

endmodule

// ==== jtag_driver.sv ====
// paced JTAG host driver
// runs handshaked scan commands onto TCK/TMS/TDI and gathers TDO
`timescale 1ns/1ps
`include "jtag_macros.svh"

module jtag_driver #(
  parameter int tick_delay = `JTAG_TICK_DELAY
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      enable,
  input  logic                      init_done,
  input  logic                      req,
  input  jtag_pkg::cmd_word_u       cmd,
  input  logic                      tdo_data,
  input  logic                      tdo_driven,
  output logic                      ack,
  output logic [`JTAG_DR_WIDTH-1:0] rsp_data,
  output logic                      rsp_fault,
  output logic                      tck,
  output logic                      tms,
  output logic                      tdi
);

  localparam int idx_w = $clog2(`JTAG_DR_WIDTH);
  localparam int ir_idx_w = $clog2(`JTAG_IR_WIDTH);

  localparam logic [1:0] st_wait = 2'd0;
  localparam logic [1:0] st_run = 2'd1;
  localparam logic [1:0] st_ack = 2'd2;

  logic [31:0]         tick_count;
  logic [31:0]         tick_next;
  logic                r_reset;
  logic                init_done_sticky;
  logic                advance;
  logic                step;
  logic                load;
  logic [1:0]          run_state;
  logic                phase;
  logic [5:0]          period;
  jtag_pkg::cmd_word_u cmd_q;
  jtag_pkg::scan_op_e  op;
  logic [5:0]          dr_len;
  logic [5:0]          pre_len;
  logic [5:0]          shift_len;
  logic [5:0]          total_len;
  logic [5:0]          bit_pos;
  logic                in_shift;
  logic                tms_val;
  logic                tdi_val;
  logic                sample_pend;
  logic [idx_w-1:0]    sample_idx;

  // tick pacer, one pin step each time the counter wraps
  assign tick_next = (tick_count == 32'd0) ? 32'(tick_delay) : tick_count - 32'd1;
  assign advance = enable && init_done_sticky;
  assign step = advance && (tick_count == 32'd0);
  assign load = advance && (run_state == st_wait) && req;

  assign op = cmd_q.ir_view.op;

  // scan length clamps to the data register width
  always_comb begin
    if (cmd_q.dr_view.len_m1 >= 6'(`JTAG_DR_WIDTH - 1)) begin
      dr_len = 6'(`JTAG_DR_WIDTH);
    end else begin
      dr_len = cmd_q.dr_view.len_m1 + 6'd1;
    end
  end

  // TMS path per TCK period
  // ir and dr scans start from run-test/idle so after reset issue op_tap_reset or op_idle first
  always_comb begin
    pre_len   = (op == jtag_pkg::op_ir_scan) ? 6'd4 : 6'd3;
    shift_len = (op == jtag_pkg::op_ir_scan) ? 6'(`JTAG_IR_WIDTH) : dr_len;
    bit_pos   = period - pre_len;
    in_shift  = 1'b0;
    tdi_val   = 1'b0;
    case (op)
      jtag_pkg::op_tap_reset: begin
        total_len = 6'd6;
        tms_val   = (period < 6'd5);
      end
      jtag_pkg::op_idle: begin
        total_len = 6'd1;
        tms_val   = 1'b0;
      end
      default: begin
        total_len = pre_len + shift_len + 6'd2;
        in_shift  = (period >= pre_len) && (bit_pos < shift_len);
        if (period < pre_len) begin
          // select-dr, then select-ir for IR scans, then capture and shift
          if (op == jtag_pkg::op_ir_scan) begin
            tms_val = (period < 6'd2);
          end else begin
            tms_val = (period == 6'd0);
          end
        end else if (in_shift) begin
          tms_val = (bit_pos == shift_len - 6'd1);
        end else begin
          // exit1 to update on one, update to idle on zero
          tms_val = (bit_pos == shift_len);
        end
        if (op == jtag_pkg::op_ir_scan) begin
          tdi_val = in_shift && cmd_q.ir_view.instr[bit_pos[ir_idx_w-1:0]];
        end else begin
          tdi_val = in_shift && cmd_q.dr_view.data[bit_pos[idx_w-1:0]];
        end
      end
    endcase
  end

  always_ff @(posedge clock) begin
    r_reset <= reset;
    if (reset || r_reset) begin
      tick_count       <= 32'(tick_delay);
      init_done_sticky <= 1'b0;
      run_state        <= st_wait;
      phase            <= 1'b0;
      period           <= '0;
      sample_pend      <= 1'b0;
      ack              <= 1'b0;
      rsp_fault        <= 1'b0;
      tck              <= 1'b0;
      tms              <= 1'b0;
      tdi              <= 1'b0;
    end else begin
      init_done_sticky <= init_done | init_done_sticky;
      if (advance) begin
        tick_count <= tick_next;
        // tdo is taken one clock after the rise so the target has retimed it
        if (sample_pend) begin
          sample_pend <= 1'b0;
          if (!tdo_driven) begin
            rsp_fault <= 1'b1;
          end
        end
        case (run_state)
          st_wait: begin
            if (load) begin
              period    <= '0;
              phase     <= 1'b0;
              rsp_fault <= 1'b0;
              run_state <= st_run;
            end
          end
          st_run: begin
            if (step && !phase) begin
              tck <= 1'b0;
              if (period == total_len) begin
                tms       <= 1'b0;
                tdi       <= 1'b0;
                ack       <= 1'b1;
                run_state <= st_ack;
              end else begin
                tms   <= tms_val;
                tdi   <= tdi_val;
                phase <= 1'b1;
              end
            end else if (step) begin
              tck         <= 1'b1;
              phase       <= 1'b0;
              period      <= period + 6'd1;
              sample_pend <= in_shift;
            end
          end
          st_ack: begin
            // pins stay idle while the host keeps req high
            if (!req) begin
              ack       <= 1'b0;
              run_state <= st_wait;
            end
          end
          default: run_state <= st_wait;
        endcase
      end
    end
  end

  // command copy and captured data, right-aligned
  always_ff @(posedge clock) begin
    if (load) begin
      cmd_q    <= cmd;
      rsp_data <= '0;
    end else if (advance && sample_pend) begin
      rsp_data[sample_idx] <= tdo_data;
    end
    if (step && phase) begin
      sample_idx <= bit_pos[idx_w-1:0];
    end
  end

endmodule

// ==== jtag_pkg.sv ====
// JTAG shared types
// scan operations, the two views of a command word and the TAP states
`include "jtag_macros.svh"

package jtag_pkg;

  // operation in the top two bits of every command word
  typedef enum logic [1:0] {
    op_tap_reset = 2'd0,
    op_ir_scan   = 2'd1,
    op_dr_scan   = 2'd2,
    op_idle      = 2'd3
  } scan_op_e;

  // one 40-bit word read as an IR scan or as a DR scan
  // data goes out least significant bit first
  typedef union packed {
    struct packed {
      scan_op_e                                    op;
      logic [`JTAG_CMD_WIDTH-2-`JTAG_IR_WIDTH-1:0] reserved;
      logic [`JTAG_IR_WIDTH-1:0]                   instr;
    } ir_view;
    struct packed {
      scan_op_e                                    op;
      logic [`JTAG_CMD_WIDTH-2-`JTAG_DR_WIDTH-1:0] len_m1;
      logic [`JTAG_DR_WIDTH-1:0]                   data;
    } dr_view;
  } cmd_word_u;

  // standard TAP controller encoding
  typedef enum logic [3:0] {
    tap_exit2_dr         = 4'h0,
    tap_exit1_dr         = 4'h1,
    tap_shift_dr         = 4'h2,
    tap_pause_dr         = 4'h3,
    tap_select_ir        = 4'h4,
    tap_update_dr        = 4'h5,
    tap_capture_dr       = 4'h6,
    tap_select_dr        = 4'h7,
    tap_exit2_ir         = 4'h8,
    tap_exit1_ir         = 4'h9,
    tap_shift_ir         = 4'hA,
    tap_pause_ir         = 4'hB,
    tap_run_test_idle    = 4'hC,
    tap_update_ir        = 4'hD,
    tap_capture_ir       = 4'hE,
    tap_test_logic_reset = 4'hF
  } tap_state_e;

endpackage

// ==== jtag_macros.svh ====
// JTAG subsystem widths, instruction codes and pacing defaults
// shared by the host driver, the TAP target and the testbench
`ifndef JTAG_MACROS_SVH
`define JTAG_MACROS_SVH

// register and command widths
`define JTAG_IR_WIDTH 4
`define JTAG_DR_WIDTH 32
`define JTAG_CMD_WIDTH 40

// system clocks per half TCK period minus one
`define JTAG_TICK_DELAY 3

// instruction codes, anything else selects bypass
`define JTAG_INSTR_IDCODE 4'd1
`define JTAG_INSTR_USER 4'd8
`define JTAG_INSTR_BYPASS 4'd15

// identification word, bit 0 is always set
`define JTAG_IDCODE_VALUE 32'h1A3B_C0D5

`endif
